//--- vlog.f
hdl/mem_pkg.sv
hdl/axi_pkg.sv
hdl/store_fifo.sv
hdl/axi_write_issuer.sv
hdl/pending_write_counter.sv
hdl/mmio_ctrl_fsm.sv
hdl/mmio_dcache.sv
verif/axi_mem_model.sv
verif/tb_mmio_dcache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_mmio_dcache -f vlog.f
./obj_dir/Vtb_mmio_dcache | tee sim.log
grep -q "All tests passed" sim.log

//--- verif/tb_mmio_dcache.sv
module tb_mmio_dcache
    import mem_pkg::*, axi_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DELAY_BITS  = 2;
    localparam int MAX_DELAY   = 1 << DELAY_BITS;
    localparam int N_RANDOM    = 200;
    localparam int N_ACCESSES  = N_RANDOM + 23;
    localparam int TIMEOUT     = N_ACCESSES * MAX_DELAY * 4 + 2000;
    localparam int HOLD_CYCLES = 20;
    localparam logic [31:0]       LFSR_TAPS = 32'h8020_0003;
    localparam logic [ADDR_W-1:0] BASE      = 32'h1fd0_0000;

    logic              clk = 1'b0;
    logic              rst;
    logic              hold;
    logic              stall_m;
    logic              dstall;
    logic              mem_en;
    logic              mem_write;
    logic              mem_uncached;
    logic [ADDR_W-1:0] mem_pa;
    logic [SIZE_W-1:0] mem_size;
    logic [MASK_W-1:0] wmask;
    logic [DATA_W-1:0] wdata_in;
    logic [DATA_W-1:0] rdata_out;
    logic [ADDR_W-1:0] araddr;
    logic [AXI_LEN_W-1:0]  arlen;
    logic [AXI_SIZE_W-1:0] arsize;
    logic              arvalid;
    logic              arready;
    logic [DATA_W-1:0] rdata;
    logic              rvalid;
    logic              rready;
    logic [ADDR_W-1:0] awaddr;
    logic [AXI_LEN_W-1:0]  awlen;
    logic [AXI_SIZE_W-1:0] awsize;
    logic              awvalid;
    logic              awready;
    logic [DATA_W-1:0] wdata;
    logic [MASK_W-1:0] wstrb;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    logic              bready;

    logic [31:0]       lfsr = 32'hb40c;
    store_entry        store_log[$];  // program order
    logic [ADDR_W-1:0] aw_expect[$];
    int cycles = 0;
    int owed = 0;       // acks owed by aw handshakes less bvalid pulses
    int n_stores = 0;
    int n_loads = 0;
    int aw_count = 0;
    int ar_count = 0;

    mmio_dcache UUT (
        .clk, .rst, .stallM(stall_m), .dstall, .M_mem_pa(mem_pa), .M_mem_en(mem_en),
        .M_mem_write(mem_write), .M_mem_uncached(mem_uncached), .M_wmask(wmask),
        .M_mem_size(mem_size), .M_wdata(wdata_in), .M_rdata(rdata_out),
        .araddr, .arlen, .arsize, .arvalid, .arready, .rdata, .rvalid, .rready,
        .awaddr, .awlen, .awsize, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready, .bvalid, .bready
    );

    axi_mem_model #(.DELAY_BITS(DELAY_BITS)) u_mem (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return v;
    endfunction

    // replays every store so far onto the addressed word
    function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] addr);
        logic [DATA_W-1:0] word;
        int i;
        int b;
        word = '0;
        for (i = 0; i < store_log.size(); i++) begin
            if (store_log[i].waddr[ADDR_W-1:2] == addr[ADDR_W-1:2]) begin
                for (b = 0; b < MASK_W; b++) begin
                    if (store_log[i].wstrb[b]) begin
                        word[8*b +: 8] = store_log[i].wdata[8*b +: 8];
                    end
                end
            end
        end
        return word;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("** Error: %s is %h, expected %h", name, got, exp));
        end
    endtask

    // holds one access until dstall and stallM are both low
    task automatic access(input logic wr, input logic uc, input logic [ADDR_W-1:0] addr,
                          input logic [MASK_W-1:0] mask, input logic [DATA_W-1:0] data,
                          input int hold_m, output int stalls);
        int left;
        logic done;
        left = hold_m;
        stalls = 0;
        done = 1'b0;
        @(posedge clk);
        mem_en       <= 1'b1;
        mem_write    <= wr;
        mem_uncached <= uc;
        mem_pa       <= addr;
        mem_size     <= 2'd2;
        wmask        <= mask;
        wdata_in     <= data;
        stall_m      <= (left > 0);
        if (uc && wr) begin
            store_log.push_back(store_entry'{waddr: addr, wsize: 2'd2, wstrb: mask, wdata: data});
            aw_expect.push_back(addr);
            n_stores++;
        end
        if (uc && !wr) begin
            n_loads++;
        end
        while (!done) begin
            @(negedge clk);
            if (dstall) begin
                stalls++;
            end else if (!stall_m) begin
                done = 1'b1;
            end else begin
                left--;
            end
            @(posedge clk);
            stall_m <= !done && (left > 0);
        end
        mem_en <= 1'b0;
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (mem_en && mem_uncached && !mem_write && !dstall) begin
                check("M_rdata", rdata_out, ref_read(mem_pa));
            end else begin
                check("M_rdata", rdata_out, 0);
            end
            if (arvalid && (awvalid || wvalid || owed != 0)) begin
                abort_run("arvalid was raised while a write was still outstanding");
            end
            if (arvalid && arready) begin
                check("arlen", arlen, 0);
                check("arsize", arsize, 2);
                ar_count++;
            end
            if (rvalid) begin
                check("rready", rready, 1);
            end
            if (awvalid && awready) begin
                if (aw_expect.size() == 0) begin
                    abort_run("an AW handshake happened with no store outstanding");
                end else begin
                    check("awaddr", awaddr, aw_expect.pop_front());
                end
                check("awlen", awlen, 0);
                check("awsize", awsize, 2);
                aw_count++;
            end
            if (wvalid && wready) begin
                check("wlast", wlast, 1);
            end
            if (bvalid) begin
                check("bready", bready, 1);
            end
            owed = owed + int'(awvalid && awready) - int'(bvalid);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            abort_run("timeout: the run did not finish within the cycle limit");
        end
    end

    initial begin
        int stalls;
        int i;
        rst          = 1'b1;
        hold         = 1'b0;
        stall_m      = 1'b0;
        mem_en       = 1'b0;
        mem_write    = 1'b0;
        mem_uncached = 1'b0;
        mem_pa       = '0;
        mem_size     = '0;
        wmask        = '0;
        wdata_in     = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check("arvalid", arvalid, 0);
        check("awvalid", awvalid, 0);
        check("wvalid", wvalid, 0);
        check("wlast", wlast, 0);
        check("rready", rready, 1);
        check("bready", bready, 1);
        check("dstall", dstall, 0);

        // cached path is not modelled so these pass straight through
        access(1'b1, 1'b0, BASE, 4'hf, 32'hdead_beef, 0, stalls);
        check("dstall", stalls, 0);
        access(1'b0, 1'b0, BASE, '0, '0, 0, stalls);
        check("dstall", stalls, 0);

        for (i = 0; i < N_RANDOM; i++) begin
            access(1'(rand_bits(1)), 1'b1, BASE + (rand_bits(4) << 2), 4'(rand_bits(4)),
                   rand_bits(32), int'(rand_bits(2)), stalls);
        end

        // drain first and freeze the write channels so the issuer holds one store
        access(1'b0, 1'b1, BASE, '0, '0, 0, stalls);
        hold <= 1'b1;
        access(1'b1, 1'b1, BASE + 32'h40, 4'hf, 32'h0, 0, stalls);
        @(negedge clk);
        while (!awvalid) begin
            @(negedge clk);
        end
        for (i = 0; i < SB_DEPTH; i++) begin
            access(1'b1, 1'b1, BASE + 32'h44 + 4 * i, 4'hf, 32'ha500_0000 + i, 0, stalls);
            check("dstall", stalls, 0);
        end
        fork
            begin
                repeat (HOLD_CYCLES) @(posedge clk);
                hold <= 1'b0;
            end
        join_none
        access(1'b1, 1'b1, BASE + 32'h64, 4'h3, 32'h1234_5678, 0, stalls);
        check("dstall", stalls >= HOLD_CYCLES - 1, 1);

        for (i = 0; i < 10; i++) begin
            access(1'b0, 1'b1, BASE + 32'h40 + 4 * i, '0, '0, i % 3, stalls);
        end
        check("arvalid handshakes", ar_count, n_loads);
        check("awvalid handshakes", aw_count, n_stores);
        $display("All tests passed");
        $finish;
    end

endmodule

//--- verif/axi_mem_model.sv
module axi_mem_model
    import mem_pkg::*;
#(
    parameter int DELAY_BITS = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,    // keeps awready and wready low
    input  logic [ADDR_W-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [DATA_W-1:0] wdata,
    input  logic [MASK_W-1:0] wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic              bvalid,  // bready assumed high
    input  logic [ADDR_W-1:0] araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [DATA_W-1:0] rdata,
    output logic              rvalid   // rready assumed high
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic [DATA_W-1:0]     mem [logic [ADDR_W-1:0]]; // sparse and word addressed
    logic [31:0]           lfsr = 32'hb40c;
    logic                  aw_ok;
    logic                  w_ok;
    logic                  ar_ok;
    logic                  have_aw;
    logic                  have_w;
    logic                  b_busy;
    logic                  r_busy;
    logic [ADDR_W-1:0]     wr_addr;
    logic [ADDR_W-1:0]     rd_addr;
    logic [DATA_W-1:0]     wr_data;
    logic [MASK_W-1:0]     wr_strb;
    logic [DELAY_BITS-1:0] b_cnt;
    logic [DELAY_BITS-1:0] r_cnt;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = (lfsr >> 1) ^ (lfsr[0] ? LFSR_TAPS : 32'h0);
        end
        return v;
    endfunction

    function automatic logic [DATA_W-1:0] merge_word(input logic [DATA_W-1:0] old,
                                                     input logic [DATA_W-1:0] data,
                                                     input logic [MASK_W-1:0] strb);
        logic [DATA_W-1:0] word;
        int b;
        word = old;
        for (b = 0; b < MASK_W; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = data[8*b +: 8];
            end
        end
        return word;
    endfunction

    // one write in flight at a time including its response
    assign awready = aw_ok && !have_aw && !b_busy && !hold;
    assign wready  = w_ok && !have_w && !b_busy && !hold;
    assign arready = ar_ok && !r_busy;

    always @(posedge clk) begin
        if (rst) begin
            aw_ok   <= 1'b0;
            w_ok    <= 1'b0;
            ar_ok   <= 1'b0;
            have_aw <= 1'b0;
            have_w  <= 1'b0;
            b_busy  <= 1'b0;
            r_busy  <= 1'b0;
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            aw_ok <= 1'(rand_bits(1));
            w_ok  <= 1'(rand_bits(1));
            ar_ok <= 1'(rand_bits(1));
            if (awvalid && awready) begin
                have_aw <= 1'b1;
                wr_addr <= {awaddr[ADDR_W-1:2], 2'b00};
            end
            if (wvalid && wready) begin
                have_w  <= 1'b1;
                wr_data <= wdata;
                wr_strb <= wstrb;
            end
            if (have_aw && have_w) begin
                mem[wr_addr] = merge_word(mem.exists(wr_addr) ? mem[wr_addr] : '0,
                                          wr_data, wr_strb);
                have_aw <= 1'b0;
                have_w  <= 1'b0;
                b_busy  <= 1'b1;
                b_cnt   <= DELAY_BITS'(rand_bits(DELAY_BITS));
            end
            bvalid <= b_busy && b_cnt == 0;
            if (b_busy) begin
                if (b_cnt == 0) begin
                    b_busy <= 1'b0;
                end else begin
                    b_cnt <= b_cnt - 1'b1;
                end
            end
            if (arvalid && arready) begin
                r_busy  <= 1'b1;
                rd_addr <= {araddr[ADDR_W-1:2], 2'b00};
                r_cnt   <= DELAY_BITS'(rand_bits(DELAY_BITS));
            end
            rvalid <= r_busy && r_cnt == 0;
            if (r_busy) begin
                if (r_cnt == 0) begin
                    r_busy <= 1'b0;
                    rdata  <= mem.exists(rd_addr) ? mem[rd_addr] : '0; // unwritten reads 0
                end else begin
                    r_cnt <= r_cnt - 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/mmio_dcache.sv
module mmio_dcache
    import mem_pkg::*, axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // pipeline
    input  logic                  stallM,
    output logic                  dstall,
    input  logic [ADDR_W-1:0]     M_mem_pa,
    input  logic                  M_mem_en,
    input  logic                  M_mem_write,
    input  logic                  M_mem_uncached,
    input  logic [MASK_W-1:0]     M_wmask,
    input  logic [SIZE_W-1:0]     M_mem_size,
    input  logic [DATA_W-1:0]     M_wdata,
    output logic [DATA_W-1:0]     M_rdata,
    // axi master
    output logic [ADDR_W-1:0]     araddr,
    output logic [AXI_LEN_W-1:0]  arlen,
    output logic [AXI_SIZE_W-1:0] arsize,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [DATA_W-1:0]     rdata,
    input  logic                  rvalid,
    output logic                  rready,
    output logic [ADDR_W-1:0]     awaddr,
    output logic [AXI_LEN_W-1:0]  awlen,
    output logic [AXI_SIZE_W-1:0] awsize,
    output logic                  awvalid,
    input  logic                  awready,
    output logic [DATA_W-1:0]     wdata,
    output logic [MASK_W-1:0]     wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready,
    input  logic                  bvalid,
    output logic                  bready
);

    logic       push;
    store_entry push_data;
    logic       full;
    logic       empty;
    store_entry head;
    logic       pop;
    logic       issued;
    logic       write_busy;
    logic       writes_pending;

    assign bready = 1'b1; // responses always accepted

    mmio_ctrl_fsm u_fsm (
        .clk, .rst, .stallM, .M_mem_en, .M_mem_write, .M_mem_uncached,
        .M_mem_pa, .M_mem_size, .M_wmask, .M_wdata, .dstall, .M_rdata,
        .full, .empty, .push, .push_data, .write_busy, .writes_pending,
        .araddr, .arlen, .arsize, .arvalid, .arready, .rdata, .rvalid, .rready
    );

    store_fifo #(
        .entry_t(store_entry)
    ) u_store_fifo (
        .clk, .rst, .push, .push_data, .pop, .head, .empty, .full
    );

    axi_write_issuer u_issuer (
        .clk, .rst, .empty, .head, .pop, .issued, .write_busy,
        .awaddr, .awlen, .awsize, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready
    );

    pending_write_counter u_pending (
        .clk, .rst, .issued, .bvalid, .writes_pending
    );

endmodule

//--- hdl/mmio_ctrl_fsm.sv
module mmio_ctrl_fsm
    import mem_pkg::*, axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // pipeline
    input  logic                  stallM,
    input  logic                  M_mem_en,
    input  logic                  M_mem_write,
    input  logic                  M_mem_uncached,
    input  logic [ADDR_W-1:0]     M_mem_pa,
    input  logic [SIZE_W-1:0]     M_mem_size,
    input  logic [MASK_W-1:0]     M_wmask,
    input  logic [DATA_W-1:0]     M_wdata,
    output logic                  dstall,
    output logic [DATA_W-1:0]     M_rdata,
    // store buffer
    input  logic                  full,
    input  logic                  empty,
    output logic                  push,
    output store_entry            push_data,
    // write side status
    input  logic                  write_busy,
    input  logic                  writes_pending,
    // ar and r channels
    output logic [ADDR_W-1:0]     araddr,
    output logic [AXI_LEN_W-1:0]  arlen,
    output logic [AXI_SIZE_W-1:0] arsize,
    output logic                  arvalid,
    input  logic                  arready,
    input  logic [DATA_W-1:0]     rdata,
    input  logic                  rvalid,
    output logic                  rready
);

    typedef enum logic [1:0] {
        IDLE,
        UNCACHED_READ,
        SAVE_RESULT
    } state_t;

    state_t            state;
    logic              saved;       // current store already in the buffer
    logic [DATA_W-1:0] saved_rdata;

    logic is_load;
    logic is_store;
    logic drained;
    logic load_stall;
    logic store_stall;

    // cached accesses (M_mem_uncached low) fall through untouched
    assign is_load  = M_mem_en && M_mem_uncached && !M_mem_write;
    assign is_store = M_mem_en && M_mem_uncached && M_mem_write;

    // every earlier store sent and acknowledged
    assign drained = empty && !write_busy && !writes_pending;

    assign load_stall  = is_load && (state != SAVE_RESULT);
    assign store_stall = is_store && (state != IDLE || (full && !saved));

    assign dstall = (state == IDLE) ? (load_stall || store_stall) : (state != SAVE_RESULT);

    assign push      = (state == IDLE) && is_store && !full && !saved;
    assign push_data = '{waddr: M_mem_pa, wsize: M_mem_size, wstrb: M_wmask, wdata: M_wdata};

    assign M_rdata = (state == SAVE_RESULT) ? saved_rdata : '0;
    assign arlen   = AXI_LEN_SINGLE;
    assign rready  = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            saved <= 1'b0;
        end else begin
            if (push) begin
                saved <= 1'b1;
            end
            if (!dstall && !stallM) begin
                saved <= 1'b0; // pipeline moved on
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            arvalid <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (is_load && drained) begin
                        arvalid <= 1'b1;
                        state   <= UNCACHED_READ;
                    end
                end
                UNCACHED_READ: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                    end
                    if (rvalid) begin
                        state <= SAVE_RESULT;
                    end
                end
                SAVE_RESULT: begin
                    if (!stallM) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // read address and returned word
    always_ff @(posedge clk) begin
        if (state == IDLE && is_load && drained) begin
            araddr <= M_mem_pa;
            arsize <= {{(AXI_SIZE_W - SIZE_W){1'b0}}, M_mem_size};
        end
        if (state == UNCACHED_READ && rvalid) begin
            saved_rdata <= rdata;
        end
    end

    assert property (@(posedge clk) disable iff (rst) arvalid |-> state == UNCACHED_READ)
        else $error("mmio_ctrl_fsm: arvalid outside UNCACHED_READ");

endmodule

//--- hdl/pending_write_counter.sv
module pending_write_counter
    import axi_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic issued, // w beat accepted
    input  logic bvalid, // bready is always high
    output logic writes_pending
);

    logic [PEND_W-1:0] count;

    assign writes_pending = (count != 0);

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({issued, bvalid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    // a response always belongs to an earlier w beat
    assert property (@(posedge clk) disable iff (rst) bvalid |-> count != 0)
        else $error("pending_write_counter: bvalid with nothing outstanding");

    assert property (@(posedge clk) disable iff (rst)
        issued && !bvalid |-> count < MAX_PENDING)
        else $error("pending_write_counter: overflow");

endmodule

//--- hdl/axi_write_issuer.sv
module axi_write_issuer
    import mem_pkg::*, axi_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // store buffer head
    input  logic                  empty,
    input  store_entry            head,
    output logic                  pop,
    // to counter and fsm
    output logic                  issued,
    output logic                  write_busy,
    // aw channel
    output logic [ADDR_W-1:0]     awaddr,
    output logic [AXI_LEN_W-1:0]  awlen,
    output logic [AXI_SIZE_W-1:0] awsize,
    output logic                  awvalid,
    input  logic                  awready,
    // w channel
    output logic [DATA_W-1:0]     wdata,
    output logic [MASK_W-1:0]     wstrb,
    output logic                  wlast,
    output logic                  wvalid,
    input  logic                  wready
);

    logic aw_done;
    logic w_done;

    assign aw_done = awvalid && awready;
    assign w_done  = wvalid && wready;

    // next entry only once both aw and w of the last one are gone
    assign write_busy = awvalid || wvalid;
    assign pop        = !empty && !write_busy;
    assign issued     = w_done;

    assign awlen = AXI_LEN_SINGLE;

    // address and data registers loaded on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            awaddr <= head.waddr;
            awsize <= {{(AXI_SIZE_W - SIZE_W){1'b0}}, head.wsize};
            wdata  <= head.wdata;
            wstrb  <= head.wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            wlast   <= 1'b0;
        end else if (pop) begin
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            wlast   <= 1'b1; // single beat
        end else begin
            if (aw_done) begin
                awvalid <= 1'b0;
            end
            if (w_done) begin
                wvalid <= 1'b0;
                wlast  <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("axi_write_issuer: awvalid dropped before awready");

endmodule

//--- hdl/store_fifo.sv
module store_fifo
    import mem_pkg::*;
#(
    parameter type entry_t = store_entry
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t head,
    output logic   empty,
    output logic   full
);

    entry_t mem [SB_DEPTH];

    logic [SB_PTR_W-1:0] rd_ptr;
    logic [SB_PTR_W-1:0] wr_ptr;
    logic [SB_PTR_W:0]   count; // one extra bit so all slots are usable

    logic do_push;
    logic do_pop;

    assign empty = (count == 0);
    assign full  = (count == SB_DEPTH);

    // full fifo still takes a push when the head leaves in the same cycle
    assign do_push = push && (!full || pop);
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps since depth is a power of two
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) push && full |-> pop)
        else $error("store_fifo: push while full");

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("store_fifo: pop while empty");

endmodule

//--- hdl/axi_pkg.sv
package axi_pkg;

    localparam int AXI_LEN_W  = 8;
    localparam int AXI_SIZE_W = 3;

    // every transfer here is a single beat
    localparam logic [AXI_LEN_W-1:0] AXI_LEN_SINGLE = '0;

    // writes issued but not yet answered on b
    localparam int MAX_PENDING = 15;
    localparam int PEND_W      = $clog2(MAX_PENDING + 1);

endpackage

//--- hdl/mem_pkg.sv
package mem_pkg;

    // pipeline side widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int MASK_W = DATA_W / 8;

    // size code 0 is byte, 1 half and 2 word
    localparam int SIZE_W = 2;

    // uncached store buffer
    localparam int SB_DEPTH = 8;
    localparam int SB_PTR_W = $clog2(SB_DEPTH);

    // one pending uncached store
    typedef struct packed {
        logic [ADDR_W-1:0] waddr;
        logic [SIZE_W-1:0] wsize;
        logic [MASK_W-1:0] wstrb;
        logic [DATA_W-1:0] wdata; // lanes already placed as on axi
    } store_entry;

endpackage
